/* source/sdmac_defs.svh */
// Bus widths, register offsets and status bit positions shared by the SDMAC RTL and testbench
`ifndef SDMAC_DEFS_SVH
`define SDMAC_DEFS_SVH

// Bus widths
`define SDMAC_ADDR_W 8
`define SDMAC_DATA_W 32
`define SDMAC_WTC_W 24
`define SDMAC_CONTR_W 8

// FIFO depth in words
`define SDMAC_FIFO_DEPTH 8

// Read-only version value
`define SDMAC_VERSION 32'h0000_0003

// CPU register offsets
`define REG_WTC 8'h04
`define REG_CONTR 8'h08
`define REG_ACR 8'h0C
`define REG_ST_DMA 8'h10
`define REG_FLUSH 8'h14
`define REG_CLR_INT 8'h18
`define REG_ISTR 8'h1C
`define REG_VERSION 8'h20
`define REG_SP_DMA 8'h3C
`define REG_SSPBDAT 8'h58

// WD33C93 window, upper address nibble
`define WD_WINDOW 4'h4

// ISTR bits
`define ISTR_TC_BIT 0
`define ISTR_EMPTY_BIT 1
`define ISTR_FULL_BIT 2
`define ISTR_ACTIVE_BIT 3

// CONTR bits
`define CONTR_INTEN_BIT 0

`endif

/* source/sdmac_pkg.sv */
// Enum types for the register read select and the DMA engine state, referenced by scoped name
package sdmac_pkg;

  // Register driven onto rdata, chosen by the decoder
  typedef enum logic [2:0] {
    rs_none    = 3'd0, // Unmapped, reads zero
    rs_wtc     = 3'd1,
    rs_contr   = 3'd2,
    rs_acr     = 3'd3,
    rs_istr    = 3'd4,
    rs_sspbdat = 3'd5,
    rs_version = 3'd6
  } reg_sel_e;

  // DMA engine FSM
  typedef enum logic [1:0] {
    st_idle      = 2'd0, // No transfer
    st_wait_data = 2'd1, // Counting transfer, FIFO empty
    st_mem_write = 2'd2, // Memory write outstanding
    st_drain     = 2'd3  // Flush, emptying FIFO to memory
  } dma_state_e;

endpackage

/* source/addr_decoder.sv */
// Turns CPU strobe bus accesses into one-cycle register and action strobes, read select and ack
`include "sdmac_defs.svh"

module addr_decoder (
  input  logic                     sclk,
  input  logic                     reset,
  input  logic [`SDMAC_ADDR_W-1:0] addr,       // CPU register address
  input  logic                     dmac_n,     // Chip select
  input  logic                     as_n,       // Address strobe
  input  logic                     rw,         // High for read
  output sdmac_pkg::reg_sel_e      rd_sel,     // Registered, valid with ack
  output logic                     contr_wr,
  output logic                     acr_wr,
  output logic                     wtc_wr,
  output logic                     sspbdat_wr,
  output logic                     st_dma,
  output logic                     sp_dma,
  output logic                     clr_int,
  output logic                     flush,
  output logic                     wdregreq,   // WD33C93 window access
  output logic                     ack
);

  logic                valid;    // Access in progress
  logic                valid_q;  // Previous cycle's valid
  logic                first;    // First cycle of an access
  logic                wd_hit;
  logic                ack_q;
  sdmac_pkg::reg_sel_e sel_next;

  assign valid = ~(dmac_n | as_n);
  assign first = valid & ~valid_q; // One strobe per access, however long
  assign wd_hit = valid & (addr[`SDMAC_ADDR_W-1 -: 4] == `WD_WINDOW);
  assign wdregreq = wd_hit; // Held for the whole access

  // Read decode
  always_comb begin
    case (addr)
      `REG_WTC:     sel_next = sdmac_pkg::rs_wtc;
      `REG_CONTR:   sel_next = sdmac_pkg::rs_contr;
      `REG_ACR:     sel_next = sdmac_pkg::rs_acr;
      `REG_ISTR:    sel_next = sdmac_pkg::rs_istr;
      `REG_SSPBDAT: sel_next = sdmac_pkg::rs_sspbdat;
      `REG_VERSION: sel_next = sdmac_pkg::rs_version;
      default:      sel_next = sdmac_pkg::rs_none;
    endcase
  end

  // Write strobes
  assign contr_wr   = first & ~rw & (addr == `REG_CONTR);
  assign acr_wr     = first & ~rw & (addr == `REG_ACR);
  assign wtc_wr     = first & ~rw & (addr == `REG_WTC);
  assign sspbdat_wr = first & ~rw & (addr == `REG_SSPBDAT);

  // Action strobes, either direction
  assign st_dma  = first & (addr == `REG_ST_DMA);
  assign sp_dma  = first & (addr == `REG_SP_DMA);
  assign clr_int = first & (addr == `REG_CLR_INT);
  assign flush   = first & (addr == `REG_FLUSH);

  always_ff @(posedge sclk) begin
    if (reset) begin
      valid_q <= 1'b0;
      ack_q   <= 1'b0;
      rd_sel  <= sdmac_pkg::rs_none;
    end else begin
      valid_q <= valid;
      if (first) begin
        ack_q  <= ~wd_hit; // WD33C93 acks itself
        rd_sel <= rw ? sel_next : sdmac_pkg::rs_none;
      end else if (!valid) begin
        ack_q <= 1'b0;
      end
    end
  end

  assign ack = ack_q & valid; // Drops with as_n

endmodule

/* source/control_regs.sv */
// CPU-visible SDMAC registers with read mux, DMA command pulses and terminal-count interrupt
`include "sdmac_defs.svh"

module control_regs (
  input  logic                     sclk,
  input  logic                     reset,
  input  sdmac_pkg::reg_sel_e      rd_sel,
  input  logic                     contr_wr,
  input  logic                     acr_wr,
  input  logic                     wtc_wr,
  input  logic                     sspbdat_wr,
  input  logic                     st_dma,
  input  logic                     sp_dma,
  input  logic                     clr_int,
  input  logic                     flush,
  input  logic [`SDMAC_DATA_W-1:0] wdata,      // CPU write data
  input  logic [`SDMAC_DATA_W-1:0] cur_addr,   // Live engine address
  input  logic [`SDMAC_WTC_W-1:0]  cur_count,  // Live remaining count
  input  logic                     tc_pulse,
  input  logic                     dma_active,
  input  logic                     fifo_empty,
  input  logic                     fifo_full,
  output logic [`SDMAC_DATA_W-1:0] rdata,
  output logic                     irq_n,
  output logic                     start,
  output logic                     stop,
  output logic                     flush_req,
  output logic [`SDMAC_DATA_W-1:0] load_addr,
  output logic [`SDMAC_WTC_W-1:0]  load_count
);

  logic [`SDMAC_CONTR_W-1:0] contr_q;
  logic [`SDMAC_DATA_W-1:0]  acr_q;     // Start address as written
  logic [`SDMAC_WTC_W-1:0]   wtc_q;     // Word count as written
  logic [`SDMAC_DATA_W-1:0]  sspbdat_q; // Scratch
  logic                      acr_live;  // ACR reads engine address
  logic                      wtc_live;  // WTC reads engine count
  logic                      tc_flag;   // Sticky terminal count
  logic [`SDMAC_DATA_W-1:0]  istr;

  always_ff @(posedge sclk) begin
    if (reset) begin
      contr_q   <= '0;
      acr_q     <= '0;
      wtc_q     <= '0;
      sspbdat_q <= '0;
      acr_live  <= 1'b0;
      wtc_live  <= 1'b0;
      tc_flag   <= 1'b0;
    end else begin
      if (contr_wr) contr_q <= wdata[`SDMAC_CONTR_W-1:0];
      if (sspbdat_wr) sspbdat_q <= wdata;

      // After a start the counters track the engine until rewritten
      if (acr_wr) begin
        acr_q    <= wdata;
        acr_live <= 1'b0;
      end else if (st_dma) begin
        acr_live <= 1'b1;
      end
      if (wtc_wr) begin
        wtc_q    <= wdata[`SDMAC_WTC_W-1:0];
        wtc_live <= 1'b0;
      end else if (st_dma) begin
        wtc_live <= 1'b1;
      end

      if (tc_pulse) tc_flag <= 1'b1;     // Set wins over a same-cycle clear
      else if (clr_int) tc_flag <= 1'b0;
    end
  end

  // Commands go straight to the engine
  assign start      = st_dma;
  assign stop       = sp_dma;
  assign flush_req  = flush;
  assign load_addr  = acr_q;
  assign load_count = wtc_q;

  assign irq_n = ~(tc_flag & contr_q[`CONTR_INTEN_BIT]);

  // Status word
  always_comb begin
    istr = '0;
    istr[`ISTR_TC_BIT]     = tc_flag;
    istr[`ISTR_EMPTY_BIT]  = fifo_empty;
    istr[`ISTR_FULL_BIT]   = fifo_full;
    istr[`ISTR_ACTIVE_BIT] = dma_active;
  end

  // Read mux
  always_comb begin
    case (rd_sel)
      sdmac_pkg::rs_wtc:
        rdata = {{(`SDMAC_DATA_W-`SDMAC_WTC_W){1'b0}}, wtc_live ? cur_count : wtc_q};
      sdmac_pkg::rs_contr:
        rdata = {{(`SDMAC_DATA_W-`SDMAC_CONTR_W){1'b0}}, contr_q};
      sdmac_pkg::rs_acr:     rdata = acr_live ? cur_addr : acr_q;
      sdmac_pkg::rs_istr:    rdata = istr;
      sdmac_pkg::rs_sspbdat: rdata = sspbdat_q;
      sdmac_pkg::rs_version: rdata = `SDMAC_VERSION;
      default:               rdata = '0; // Unmapped
    endcase
  end

endmodule

/* source/word_fifo.sv */
// Synchronous word FIFO between the SCSI data port and the DMA engine, flushable
`include "sdmac_defs.svh"

module word_fifo (
  input  logic                     sclk,
  input  logic                     reset,
  input  logic                     push,
  input  logic [`SDMAC_DATA_W-1:0] push_data,
  input  logic                     pop,
  input  logic                     flush,      // Discard contents
  output logic [`SDMAC_DATA_W-1:0] pop_data,   // Head word, valid when not empty
  output logic                     empty,
  output logic                     full
);

  localparam int DEPTH = `SDMAC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`SDMAC_DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         count;
  logic                     do_push;
  logic                     do_pop;

  assign do_push = push & ~full;  // Overflow ignored
  assign do_pop  = pop & ~empty;  // Underflow ignored
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign pop_data = mem[rd_ptr];

  // Storage
  always_ff @(posedge sclk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge sclk) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

endmodule

/* source/dma_engine.sv */
// DMA FSM moving FIFO words to memory, counting address up and word count down
`include "sdmac_defs.svh"

module dma_engine (
  input  logic                     sclk,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     stop,
  input  logic                     flush_req,
  input  logic [`SDMAC_DATA_W-1:0] load_addr,
  input  logic [`SDMAC_WTC_W-1:0]  load_count,
  input  logic [`SDMAC_DATA_W-1:0] fifo_data,
  input  logic                     fifo_empty,
  input  logic                     mem_ack,    // One cycle, ends a write
  output logic                     fifo_pop,
  output logic                     mem_req,
  output logic [`SDMAC_DATA_W-1:0] mem_addr,
  output logic [`SDMAC_DATA_W-1:0] mem_wdata,
  output logic [`SDMAC_DATA_W-1:0] cur_addr,
  output logic [`SDMAC_WTC_W-1:0]  cur_count,
  output logic                     tc_pulse,   // Same edge as the last ack
  output logic                     dma_active
);

  sdmac_pkg::dma_state_e state;
  logic stop_pend;   // Stop seen during a write
  logic flush_pend;  // Flush seen during a write
  logic draining;    // Words written without counting
  logic word_done;

  assign word_done  = (state == sdmac_pkg::st_mem_write) & mem_ack;
  assign tc_pulse   = word_done & ~draining & (cur_count == `SDMAC_WTC_W'(1));
  assign dma_active = (state != sdmac_pkg::st_idle);
  assign mem_req    = (state == sdmac_pkg::st_mem_write);
  assign mem_addr   = cur_addr; // Only moves on ack

  // Take a word when heading into a write
  assign fifo_pop = ~fifo_empty &
                    (((state == sdmac_pkg::st_wait_data) & ~stop & ~flush_req) |
                     (state == sdmac_pkg::st_drain));

  always_ff @(posedge sclk) begin
    if (fifo_pop) mem_wdata <= fifo_data; // Held until ack
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      state      <= sdmac_pkg::st_idle;
      stop_pend  <= 1'b0;
      flush_pend <= 1'b0;
      draining   <= 1'b0;
      cur_addr   <= '0;
      cur_count  <= '0;
    end else begin
      case (state)
        sdmac_pkg::st_idle: begin
          stop_pend  <= 1'b0;
          flush_pend <= 1'b0;
          draining   <= 1'b0;
          if (start && load_count != '0) begin
            cur_addr  <= load_addr;
            cur_count <= load_count;
            state     <= sdmac_pkg::st_wait_data;
          end else if (flush_req) begin
            draining <= 1'b1;    // Empty leftovers at current address
            state    <= sdmac_pkg::st_drain;
          end
        end
        sdmac_pkg::st_wait_data: begin
          if (stop) begin
            state <= sdmac_pkg::st_idle;
          end else if (flush_req) begin
            draining <= 1'b1;
            state    <= sdmac_pkg::st_drain;
          end else if (!fifo_empty) begin
            state <= sdmac_pkg::st_mem_write;
          end
        end
        sdmac_pkg::st_mem_write: begin
          if (stop) stop_pend <= 1'b1;        // Finish this write first
          if (flush_req) flush_pend <= 1'b1;
          if (mem_ack) begin
            cur_addr <= cur_addr + `SDMAC_DATA_W'(4);
            if (!draining) cur_count <= cur_count - 1'b1;
            if (tc_pulse || stop || stop_pend) begin
              state <= sdmac_pkg::st_idle;
            end else if (draining || flush_req || flush_pend) begin
              draining <= 1'b1;
              state    <= sdmac_pkg::st_drain;
            end else begin
              state <= sdmac_pkg::st_wait_data;
            end
          end
        end
        sdmac_pkg::st_drain: begin
          if (fifo_empty) state <= sdmac_pkg::st_idle;
          else state <= sdmac_pkg::st_mem_write;
        end
        default: state <= sdmac_pkg::st_idle;
      endcase
    end
  end

endmodule

/* source/sdmac_top.sv */
// SDMAC core top level tying the CPU bus, SCSI data port and memory port to the internal blocks
`include "sdmac_defs.svh"

module sdmac_top (
  input  logic                     sclk,
  input  logic                     reset,
  input  logic [`SDMAC_ADDR_W-1:0] addr,
  input  logic                     dmac_n,
  input  logic                     as_n,
  input  logic                     rw,
  input  logic [`SDMAC_DATA_W-1:0] wdata,
  input  logic                     scsi_valid,
  input  logic [`SDMAC_DATA_W-1:0] scsi_data,
  input  logic                     mem_ack,
  output logic [`SDMAC_DATA_W-1:0] rdata,
  output logic                     ack,
  output logic                     wdregreq,
  output logic                     irq_n,
  output logic                     scsi_ready,
  output logic                     mem_req,
  output logic [`SDMAC_DATA_W-1:0] mem_addr,
  output logic [`SDMAC_DATA_W-1:0] mem_wdata
);

  sdmac_pkg::reg_sel_e      rd_sel;
  logic                     contr_wr;
  logic                     acr_wr;
  logic                     wtc_wr;
  logic                     sspbdat_wr;
  logic                     st_dma;
  logic                     sp_dma;
  logic                     clr_int;
  logic                     flush;
  logic                     start;
  logic                     stop;
  logic                     flush_req;
  logic [`SDMAC_DATA_W-1:0] load_addr;
  logic [`SDMAC_WTC_W-1:0]  load_count;
  logic [`SDMAC_DATA_W-1:0] cur_addr;
  logic [`SDMAC_WTC_W-1:0]  cur_count;
  logic                     tc_pulse;
  logic                     dma_active;
  logic                     fifo_pop;
  logic [`SDMAC_DATA_W-1:0] fifo_data;
  logic                     fifo_empty;
  logic                     fifo_full;

  assign scsi_ready = ~fifo_full;

  addr_decoder i_decoder (
    .sclk, .reset, .addr, .dmac_n, .as_n, .rw,
    .rd_sel, .contr_wr, .acr_wr, .wtc_wr, .sspbdat_wr,
    .st_dma, .sp_dma, .clr_int, .flush, .wdregreq, .ack
  );

  control_regs i_regs (
    .sclk, .reset, .rd_sel, .contr_wr, .acr_wr, .wtc_wr, .sspbdat_wr,
    .st_dma, .sp_dma, .clr_int, .flush, .wdata, .cur_addr, .cur_count,
    .tc_pulse, .dma_active, .fifo_empty, .fifo_full,
    .rdata, .irq_n, .start, .stop, .flush_req, .load_addr, .load_count
  );

  // A new transfer starts from an empty FIFO; flush_req drains instead
  word_fifo i_fifo (
    .sclk, .reset,
    .push      (scsi_valid & scsi_ready),
    .push_data (scsi_data),
    .pop       (fifo_pop),
    .flush     (start),
    .pop_data  (fifo_data),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

  dma_engine i_engine (
    .sclk, .reset, .start, .stop, .flush_req, .load_addr, .load_count,
    .fifo_data, .fifo_empty, .mem_ack,
    .fifo_pop, .mem_req, .mem_addr, .mem_wdata,
    .cur_addr, .cur_count, .tc_pulse, .dma_active
  );

endmodule

/* verif/tb_sdmac.sv */
// Golden-file driven testbench for sdmac_top, run from the project root with the file list
`include "sdmac_defs.svh"

module tb_sdmac;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HALF = 20;    // 40 ns period
  localparam int DRV_DLY  = 2;     // Input delay after rising edge
  localparam int OP_NS    = 3000;  // Watchdog budget per golden line

  logic                     sclk;
  logic                     reset;
  logic [`SDMAC_ADDR_W-1:0] addr;
  logic                     dmac_n;
  logic                     as_n;
  logic                     rw;
  logic [`SDMAC_DATA_W-1:0] wdata;
  logic                     scsi_valid;
  logic [`SDMAC_DATA_W-1:0] scsi_data;
  logic                     mem_ack;
  logic [`SDMAC_DATA_W-1:0] rdata;
  logic                     ack;
  logic                     wdregreq;
  logic                     irq_n;
  logic                     scsi_ready;
  logic                     mem_req;
  logic [`SDMAC_DATA_W-1:0] mem_addr;
  logic [`SDMAC_DATA_W-1:0] mem_wdata;

  integer seed = 99261;
  integer n_ops = 0;
  integer errors = 0;
  integer test_errs = 0;
  integer tests_run = 0;
  integer tests_failed = 0;
  logic   have_test = 1'b0;
  logic   ops_counted = 1'b0; // Golden lines all counted
  reg [8*32-1:0] test_name;
  logic [`SDMAC_DATA_W-1:0] wr_addr_q[$]; // Writes seen by the memory model
  logic [`SDMAC_DATA_W-1:0] wr_data_q[$];

  sdmac_top i_dut (
    .sclk, .reset, .addr, .dmac_n, .as_n, .rw, .wdata,
    .scsi_valid, .scsi_data, .mem_ack,
    .rdata, .ack, .wdregreq, .irq_n, .scsi_ready, .mem_req, .mem_addr, .mem_wdata
  );

  always #CLK_HALF sclk = ~sclk;

  // Memory model, random 1 to 4 cycle ack latency
  initial begin
    integer lat;
    forever begin
      @(posedge sclk);
      #DRV_DLY;
      if (mem_req === 1'b1) begin
        lat = 1 + ({$random(seed)} % 4);
        repeat (lat - 1) begin
          @(posedge sclk);
          #DRV_DLY;
        end
        mem_ack = 1'b1;
        wr_addr_q.push_back(mem_addr); // Stable while req waits for ack
        wr_data_q.push_back(mem_wdata);
        @(posedge sclk);
        #DRV_DLY;
        mem_ack = 1'b0;
      end
    end
  end

  // Watchdog scaled by the number of golden lines
  initial begin
    wait (ops_counted);
    #(n_ops * OP_NS + 10 * 2 * CLK_HALF);
    $display("Watchdog expired, simulation did not finish in time");
    $display("Test failures found");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[ERROR] %0s: got %h expected %h", name, got, exp);
    errors++;
    test_errs++;
  endtask

  task automatic report_fault(input string what);
    $display("Failure: %0s", what);
    errors++;
    test_errs++;
  endtask

  // Closes the running test with its result line
  task automatic close_test();
    if (have_test) begin
      tests_run++;
      if (test_errs == 0) begin
        $display("Test %0s: PASS", test_name);
      end else begin
        $display("Test %0s: FAIL (%0d errors)", test_name, test_errs);
        tests_failed++;
      end
    end
    test_errs = 0;
  endtask

  // One CPU strobe bus access, returns rdata seen with ack
  task automatic bus_access(input logic [7:0] a, input logic rd, input logic [31:0] d,
                            output logic [31:0] q);
    int waited;
    waited = 0;
    @(posedge sclk);
    #DRV_DLY;
    addr = a;
    rw = rd;
    wdata = d;
    dmac_n = 1'b0;
    as_n = 1'b0;
    @(negedge sclk);
    while (ack !== 1'b1 && waited < 20) begin
      @(negedge sclk);
      waited++;
    end
    if (ack !== 1'b1) begin
      report_fault($sformatf("no bus ack for access at address %h", a));
      q = 'x;
    end else begin
      q = rdata;
    end
    @(posedge sclk);
    #DRV_DLY;
    dmac_n = 1'b1;
    as_n = 1'b1;
    rw = 1'b1;
  endtask

  // WD33C93 window access, no ack is ever expected
  task automatic wd_access(input logic [7:0] a);
    logic req_seen;
    logic ack_seen;
    req_seen = 1'b0;
    ack_seen = 1'b0;
    @(posedge sclk);
    #DRV_DLY;
    addr = a;
    rw = 1'b1;
    dmac_n = 1'b0;
    as_n = 1'b0;
    repeat (4) begin
      @(negedge sclk);
      if (wdregreq === 1'b1) req_seen = 1'b1;
      if (ack !== 1'b0) ack_seen = 1'b1;
    end
    if (!req_seen) report_fault($sformatf("wdregreq never rose for address %h", a));
    if (ack_seen) report_fault($sformatf("ack rose for WD33C93 address %h", a));
    @(posedge sclk);
    #DRV_DLY;
    dmac_n = 1'b1;
    as_n = 1'b1;
  endtask

  // Push n incrementing words into the SCSI port
  task automatic push_words(input int n, input logic [31:0] first);
    int waited;
    for (int i = 0; i < n; i++) begin
      @(posedge sclk);
      #DRV_DLY;
      scsi_valid = 1'b1;
      scsi_data = first + i;
      waited = 0;
      @(negedge sclk);
      while (scsi_ready !== 1'b1 && waited < 200) begin
        @(negedge sclk);
        waited++;
      end
      if (scsi_ready !== 1'b1) report_fault("scsi_ready stuck low during push");
    end
    @(posedge sclk);
    #DRV_DLY;
    scsi_valid = 1'b0;
  endtask

  // Expect n memory writes at consecutive word addresses
  task automatic expect_writes(input int n, input logic [31:0] a0, input logic [31:0] d0);
    int waited;
    logic [31:0] got_a;
    logic [31:0] got_d;
    for (int i = 0; i < n; i++) begin
      waited = 0;
      while (wr_addr_q.size() == 0 && waited < 200) begin
        @(negedge sclk);
        waited++;
      end
      if (wr_addr_q.size() == 0) begin
        report_fault($sformatf("memory write %0d of %0d never arrived", i + 1, n));
      end else begin
        got_a = wr_addr_q.pop_front();
        got_d = wr_data_q.pop_front();
        if (got_a !== a0 + 4 * i) report_mismatch("mem_addr", got_a, a0 + 4 * i);
        if (got_d !== d0 + i) report_mismatch("mem_wdata", got_d, d0 + i);
      end
    end
  endtask

  // Poll ISTR until DMA active clears
  task automatic wait_idle();
    logic [31:0] st;
    int polls;
    polls = 0;
    st = '1;
    while (st[`ISTR_ACTIVE_BIT] !== 1'b0 && polls < 50) begin
      bus_access(`REG_ISTR, 1'b1, '0, st);
      polls++;
    end
    if (st[`ISTR_ACTIVE_BIT] !== 1'b0) report_fault("DMA engine never went idle");
  endtask

  initial begin
    integer fd;
    integer r;
    reg [8*32-1:0] op;
    reg [8*256-1:0] line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] q;
    logic done;
    sclk = 1'b0;
    reset = 1'b1;
    addr = '0;
    dmac_n = 1'b1;
    as_n = 1'b1;
    rw = 1'b1;
    wdata = '0;
    scsi_valid = 1'b0;
    scsi_data = '0;
    mem_ack = 1'b0;
    test_name = "none";
    done = 1'b0;

    // First pass sizes the watchdog
    fd = $fopen("verif/sdmac_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open golden file verif/sdmac_golden.txt");
      $display("Test failures found");
      $finish;
    end
    while (!$feof(fd)) begin
      r = $fgets(line, fd);
      if (r > 0) n_ops++;
    end
    $fclose(fd);
    ops_counted = 1'b1;

    repeat (3) @(posedge sclk);
    #DRV_DLY;
    reset = 1'b0;

    // Idle output levels straight out of reset
    test_name = "reset";
    have_test = 1'b1;
    @(negedge sclk);
    if (mem_req !== 1'b0) report_mismatch("mem_req", {31'b0, mem_req}, 32'h0);
    if (ack !== 1'b0) report_mismatch("ack", {31'b0, ack}, 32'h0);
    if (wdregreq !== 1'b0) report_mismatch("wdregreq", {31'b0, wdregreq}, 32'h0);
    if (irq_n !== 1'b1) report_mismatch("irq_n", {31'b0, irq_n}, 32'h1);
    if (scsi_ready !== 1'b1) report_mismatch("scsi_ready", {31'b0, scsi_ready}, 32'h1);

    fd = $fopen("verif/sdmac_golden.txt", "r");
    while (!done) begin
      r = $fscanf(fd, "%s", op);
      if (r != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        r = $fgets(line, fd); // Comment line
      end else if (op == "T") begin
        close_test();
        r = $fscanf(fd, "%s", test_name);
        have_test = 1'b1;
      end else if (op == "W") begin
        r = $fscanf(fd, "%h %h", a, b);
        bus_access(a[7:0], 1'b0, b, q);
      end else if (op == "R") begin
        r = $fscanf(fd, "%h %h", a, b);
        bus_access(a[7:0], 1'b1, '0, q);
        if (q !== b) report_mismatch($sformatf("rdata@%h", a[7:0]), q, b);
      end else if (op == "P") begin
        r = $fscanf(fd, "%h %h", a, b);
        push_words(a, b);
      end else if (op == "M") begin
        r = $fscanf(fd, "%h %h %h", a, b, c);
        expect_writes(a, b, c);
      end else if (op == "N") begin
        repeat (8) @(negedge sclk);
        if (wr_addr_q.size() != 0) report_fault("unexpected extra memory write");
      end else if (op == "I") begin
        wait_idle();
      end else if (op == "Q") begin
        r = $fscanf(fd, "%h", a);
        @(negedge sclk);
        if (irq_n !== a[0]) report_mismatch("irq_n", {31'b0, irq_n}, a);
      end else if (op == "D") begin
        r = $fscanf(fd, "%h", a);
        wd_access(a[7:0]);
      end else begin
        report_fault($sformatf("unknown golden operation %0s", op));
      end
    end
    $fclose(fd);
    close_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verif/sdmac_golden.txt */
# T name | W addr data | R addr expect | P count first | M count addr first
# N no extra writes | I wait idle | Q irq_n | D wd33c93 addr   (values in hex)
T regs
R 20 00000003
W 08 00000001
R 08 00000001
W 0C 00001000
R 0C 00001000
W 58 A5A55A5A
R 58 A5A55A5A
R 30 00000000
T wd_window
D 44
T transfer
W 04 00000005
W 10 00000000
P 5 11110000
M 5 00001000 11110000
I
N
T terminal_count
R 1C 00000003
Q 0
W 18 00000000
Q 1
R 1C 00000002
T stop
W 0C 00002000
W 04 00000006
W 10 00000000
P 2 22220000
M 2 00002000 22220000
W 3C 00000000
I
R 04 00000004
R 0C 00002008
N
T flush
P 3 33330000
R 1C 00000000
W 14 00000000
M 3 00002008 33330000
I
R 1C 00000002
N

/* filelist.f */
+incdir+source
source/sdmac_pkg.sv
source/addr_decoder.sv
source/control_regs.sv
source/word_fifo.sv
source/dma_engine.sv
source/sdmac_top.sv
verif/tb_sdmac.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_sdmac
FILELIST  := filelist.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := source/sdmac_defs.svh
BIN     := obj_dir/V$(TOP)
LOG     := sim.log
FAIL    := Test failures found

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
